// ==== rtl/b200_ctrl_pkg.sv ====
// shared constants and the command word layout for the control path
// import into a module body, or use scoped names in a port list

package b200_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths and routing
    ////////////////////////////////////////////////////////////////////////////
    localparam int CTRL_W = 64;                // command and response beat width

    localparam logic [7:0] SID_MASK    = 8'hf0; // only the upper nibble routes
    localparam logic [7:0] R0_CTRL_SID = 8'h10; // radio 0 control endpoint
    localparam logic [7:0] L0_CTRL_SID = 8'h40; // core control, also the default

    ////////////////////////////////////////////////////////////////////////////
    // setting register addresses
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [7:0] SR_CORE_MISC     = 8'd16;
    localparam logic [7:0] SR_CORE_READBACK = 8'd32;
    localparam logic [7:0] SR_CORE_GPSDO_ST = 8'd40;
    localparam logic [7:0] SR_CORE_PPS_SEL  = 8'd48;

    ////////////////////////////////////////////////////////////////////////////
    // readback constants
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [31:0] COMPAT_MAGIC = 32'hACE0BA5E;
    localparam logic [15:0] COMPAT_MAJOR = 16'd8;
    localparam logic [15:0] COMPAT_MINOR = 16'd0;

    // one radio fitted
    localparam logic [7:0] RADIO_ST = 8'd1;

    // The same 64-bit beat is read two ways. The router only needs the SID,
    // the settings decoder needs address and data as well.
    typedef union packed {
        struct packed {
            logic [55:0] rsvd;   // payload, not looked at while routing
            logic [7:0]  sid;
        } hdr;
        struct packed {
            logic [31:0] data;   // setting value
            logic [15:0] rsvd;
            logic [7:0]  addr;   // setting register address
            logic [7:0]  sid;
        } cmd;
    } ctrl_word_u;

endpackage

// ==== rtl/ctrl_demux.sv ====
// routes single-beat control commands to the core or radio 0 endpoint
// by masked SID, through one output register shared by both destinations

module ctrl_demux (
    input  logic                     radio_clk,
    input  logic                     bus_rst,
    input  b200_ctrl_pkg::ctrl_word_u i_ctrl_data,
    input  logic                     i_ctrl_valid,
    output logic                     o_ctrl_ready,
    output b200_ctrl_pkg::ctrl_word_u o_core_data,
    output logic                     o_core_valid,
    input  logic                     i_core_ready,
    output b200_ctrl_pkg::ctrl_word_u o_r0_data,
    output logic                     o_r0_valid,
    input  logic                     i_r0_ready
);
    import b200_ctrl_pkg::*;

    ctrl_word_u beat_q;        // held command
    logic       valid_q;
    logic       to_r0_q;       // destination of the held beat
    logic       to_r0_d;
    logic [7:0] sid_masked;
    logic       drain;         // held beat leaves this cycle
    logic       accept;

    ////////////////////////////////////////////////////////////////////////////
    // destination decode
    ////////////////////////////////////////////////////////////////////////////
    assign sid_masked = i_ctrl_data.hdr.sid & SID_MASK;

    always_comb begin
        case (sid_masked)
            R0_CTRL_SID: to_r0_d = 1'b1;
            L0_CTRL_SID: to_r0_d = 1'b0;
            default:     to_r0_d = 1'b0; // unknown SIDs land on the core
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // one-beat output register
    ////////////////////////////////////////////////////////////////////////////
    assign drain        = valid_q && (to_r0_q ? i_r0_ready : i_core_ready);
    assign o_ctrl_ready = !valid_q || drain;
    assign accept       = i_ctrl_valid && o_ctrl_ready;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            valid_q <= 1'b0;
            to_r0_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
            to_r0_q <= to_r0_d;
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (accept) beat_q <= i_ctrl_data;  // payload only
    end

    assign o_core_data  = beat_q;
    assign o_r0_data    = beat_q;
    assign o_core_valid = valid_q && !to_r0_q;
    assign o_r0_valid   = valid_q && to_r0_q;

    // a beat must never be offered to both endpoints
    a_one_dest: assert property (@(posedge radio_clk) disable iff (bus_rst)
        $onehot0({o_core_valid, o_r0_valid}));

endmodule

// ==== rtl/core_ctrl.sv ====
// core control endpoint: setting registers, lock and PPS synchronizers,
// PPS source select, and one readback word per accepted command

module core_ctrl (
    input  logic                               radio_clk,
    input  logic                               bus_rst,
    input  b200_ctrl_pkg::ctrl_word_u          i_cmd_data,
    input  logic                               i_cmd_valid,
    output logic                               o_cmd_ready,
    output logic [b200_ctrl_pkg::CTRL_W-1:0]   o_resp_data,
    output logic                               o_resp_valid,
    input  logic                               i_resp_ready,
    input  logic [1:0]                         i_lock_signals,
    input  logic [31:0]                        i_rb_misc,
    input  logic                               i_pps_int,
    input  logic                               i_pps_ext,
    output logic [31:0]                        o_misc_outs,
    output logic                               o_pps
);
    import b200_ctrl_pkg::*;

    logic              accept;
    logic [31:0]       misc_q, misc_d;
    logic [1:0]        rb_sel_q, rb_sel_d;
    logic [7:0]        gpsdo_st_q, gpsdo_st_d;
    logic [1:0]        pps_sel_q, pps_sel_d;
    logic [1:0]        lock_state, lock_state_r;
    logic [1:0]        gpsdo_pps_del, ext_pps_del;
    logic [CTRL_W-1:0] rb_data;
    logic              resp_valid_q;
    logic [CTRL_W-1:0] resp_q;

    assign o_cmd_ready = !resp_valid_q || i_resp_ready;
    assign accept      = i_cmd_valid && o_cmd_ready;

    ////////////////////////////////////////////////////////////////////////////
    // setting registers
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        misc_d     = misc_q;
        rb_sel_d   = rb_sel_q;
        gpsdo_st_d = gpsdo_st_q;
        pps_sel_d  = pps_sel_q;
        if (accept) begin
            case (i_cmd_data.cmd.addr)
                SR_CORE_MISC:     misc_d     = i_cmd_data.cmd.data;
                SR_CORE_READBACK: rb_sel_d   = i_cmd_data.cmd.data[1:0];
                SR_CORE_GPSDO_ST: gpsdo_st_d = i_cmd_data.cmd.data[7:0];
                SR_CORE_PPS_SEL:  pps_sel_d  = i_cmd_data.cmd.data[1:0];
                default: ;                    // unknown address, readback only
            endcase
        end
    end

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            misc_q    <= '0;
            rb_sel_q  <= '0;
            pps_sel_q <= '0;
        end else begin
            misc_q    <= misc_d;
            rb_sel_q  <= rb_sel_d;
            pps_sel_q <= pps_sel_d;
        end
    end

    // gpsdo status survives a bus reset
    always_ff @(posedge radio_clk) begin
        gpsdo_st_q <= gpsdo_st_d;
    end

    assign o_misc_outs = misc_q;

    ////////////////////////////////////////////////////////////////////////////
    // synchronizers and PPS mux
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            {lock_state_r, lock_state} <= '0;
            gpsdo_pps_del              <= '0;
            ext_pps_del                <= '0;
        end else begin
            {lock_state_r, lock_state} <= {lock_state, i_lock_signals};
            gpsdo_pps_del              <= {gpsdo_pps_del[0], i_pps_int};
            ext_pps_del                <= {ext_pps_del[0], i_pps_ext};
        end
    end

    always_comb begin
        case (pps_sel_q)
            2'd0:    o_pps = gpsdo_pps_del[1];
            2'd1:    o_pps = ext_pps_del[1];
            default: o_pps = 1'b0;            // no internal pps source here
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // readback response
    ////////////////////////////////////////////////////////////////////////////
    // uses the post-write select so a select write reads back at once
    always_comb begin
        case (rb_sel_d)
            2'd0: rb_data = {COMPAT_MAGIC, COMPAT_MAJOR, COMPAT_MINOR};
            2'd1: rb_data = {32'b0, misc_d};
            2'd2: rb_data = {16'b0, RADIO_ST, gpsdo_st_d, i_rb_misc};
            default: rb_data = {62'b0, lock_state_r};
        endcase
    end

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            resp_valid_q <= 1'b0;
        end else if (accept) begin
            resp_valid_q <= 1'b1;
        end else if (i_resp_ready) begin
            resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (accept) resp_q <= rb_data;
    end

    assign o_resp_data  = resp_q;
    assign o_resp_valid = resp_valid_q;

    // held response must not change until the arbiter takes it
    a_resp_hold: assert property (@(posedge radio_clk) disable iff (bus_rst)
        o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp_data));

endmodule

// ==== rtl/radio_ctrl_echo.sv ====
// stand-in for the absent radio 0 control endpoint
// every command comes back unchanged as its own response, one cycle later

module radio_ctrl_echo (
    input  logic                             radio_clk,
    input  logic                             bus_rst,
    input  b200_ctrl_pkg::ctrl_word_u        i_cmd_data,
    input  logic                             i_cmd_valid,
    output logic                             o_cmd_ready,
    output logic [b200_ctrl_pkg::CTRL_W-1:0] o_resp_data,
    output logic                             o_resp_valid,
    input  logic                             i_resp_ready
);
    import b200_ctrl_pkg::*;

    ctrl_word_u echo_q;      // held command word
    logic       valid_q;
    logic       accept;

    // room when empty or when the held word leaves this cycle
    assign o_cmd_ready = !valid_q || i_resp_ready;
    assign accept      = i_cmd_valid && o_cmd_ready;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (i_resp_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (accept) echo_q <= i_cmd_data;
    end

    assign o_resp_data  = echo_q;   // full word, sid included
    assign o_resp_valid = valid_q;

endmodule

// ==== rtl/resp_arbiter.sv ====
// round-robin merge of the core and radio 0 response streams
// one beat per cycle goes into the output register

module resp_arbiter (
    input  logic                             radio_clk,
    input  logic                             bus_rst,
    input  logic [b200_ctrl_pkg::CTRL_W-1:0] i_core_data,
    input  logic                             i_core_valid,
    output logic                             o_core_ready,
    input  logic [b200_ctrl_pkg::CTRL_W-1:0] i_r0_data,
    input  logic                             i_r0_valid,
    output logic                             o_r0_ready,
    output logic [b200_ctrl_pkg::CTRL_W-1:0] o_resp_data,
    output logic                             o_resp_valid,
    input  logic                             i_resp_ready
);
    import b200_ctrl_pkg::*;

    logic              out_valid_q;
    logic [CTRL_W-1:0] out_data_q;
    logic              prio_r0_q;      // radio 0 wins the next tie
    logic              take;           // output register can load
    logic              grant_core;
    logic              grant_r0;

    ////////////////////////////////////////////////////////////////////////////
    // grant
    ////////////////////////////////////////////////////////////////////////////
    assign take = !out_valid_q || i_resp_ready;

    always_comb begin
        grant_core = 1'b0;
        grant_r0   = 1'b0;
        if (take) begin
            if (i_core_valid && i_r0_valid) begin
                grant_r0   = prio_r0_q;
                grant_core = !prio_r0_q;
            end else begin
                grant_core = i_core_valid;
                grant_r0   = i_r0_valid;
            end
        end
    end

    assign o_core_ready = grant_core;
    assign o_r0_ready   = grant_r0;

    ////////////////////////////////////////////////////////////////////////////
    // output register and pointer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            out_valid_q <= 1'b0;
            prio_r0_q   <= 1'b0;
        end else begin
            if (grant_core || grant_r0) begin
                out_valid_q <= 1'b1;
                prio_r0_q   <= grant_core;   // loser of this round goes first
            end else if (i_resp_ready) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge radio_clk) begin
        if (grant_core) begin
            out_data_q <= i_core_data;
        end else if (grant_r0) begin
            out_data_q <= i_r0_data;
        end
    end

    assign o_resp_data  = out_data_q;
    assign o_resp_valid = out_valid_q;

    a_single_grant: assert property (@(posedge radio_clk) disable iff (bus_rst)
        !(grant_core && grant_r0));

endmodule

// ==== rtl/b200_ctrl_core.sv ====
// top of the control path: command demux, core and radio 0 endpoints,
// and the response arbiter, all on radio_clk

module b200_ctrl_core (
    input  logic                             radio_clk,
    input  logic                             bus_rst,
    input  b200_ctrl_pkg::ctrl_word_u        i_ctrl_data,
    input  logic                             i_ctrl_valid,
    output logic                             o_ctrl_ready,
    output logic [b200_ctrl_pkg::CTRL_W-1:0] o_resp_data,
    output logic                             o_resp_valid,
    input  logic                             i_resp_ready,
    input  logic [1:0]                       i_lock_signals,
    input  logic [31:0]                      i_rb_misc,
    input  logic                             i_pps_int,
    input  logic                             i_pps_ext,
    output logic [31:0]                      o_misc_outs,
    output logic                             o_pps
);
    import b200_ctrl_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // command side
    ////////////////////////////////////////////////////////////////////////////
    ctrl_word_u        core_cmd_data, r0_cmd_data;
    logic              core_cmd_valid, core_cmd_ready;
    logic              r0_cmd_valid, r0_cmd_ready;

    // response side
    logic [CTRL_W-1:0] core_resp_data, r0_resp_data;
    logic              core_resp_valid, core_resp_ready;
    logic              r0_resp_valid, r0_resp_ready;

    ctrl_demux u_demux (
        .radio_clk   (radio_clk),      .bus_rst     (bus_rst),
        .i_ctrl_data (i_ctrl_data),    .i_ctrl_valid(i_ctrl_valid),
        .o_ctrl_ready(o_ctrl_ready),
        .o_core_data (core_cmd_data),  .o_core_valid(core_cmd_valid),
        .i_core_ready(core_cmd_ready),
        .o_r0_data   (r0_cmd_data),    .o_r0_valid  (r0_cmd_valid),
        .i_r0_ready  (r0_cmd_ready)
    );

    core_ctrl u_core (
        .radio_clk     (radio_clk),       .bus_rst     (bus_rst),
        .i_cmd_data    (core_cmd_data),   .i_cmd_valid (core_cmd_valid),
        .o_cmd_ready   (core_cmd_ready),
        .o_resp_data   (core_resp_data),  .o_resp_valid(core_resp_valid),
        .i_resp_ready  (core_resp_ready),
        .i_lock_signals(i_lock_signals),  .i_rb_misc   (i_rb_misc),
        .i_pps_int     (i_pps_int),       .i_pps_ext   (i_pps_ext),
        .o_misc_outs   (o_misc_outs),     .o_pps       (o_pps)
    );

    radio_ctrl_echo u_radio0 (
        .radio_clk   (radio_clk),     .bus_rst     (bus_rst),
        .i_cmd_data  (r0_cmd_data),   .i_cmd_valid (r0_cmd_valid),
        .o_cmd_ready (r0_cmd_ready),
        .o_resp_data (r0_resp_data),  .o_resp_valid(r0_resp_valid),
        .i_resp_ready(r0_resp_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // response merge
    ////////////////////////////////////////////////////////////////////////////
    resp_arbiter u_arb (
        .radio_clk   (radio_clk),       .bus_rst     (bus_rst),
        .i_core_data (core_resp_data),  .i_core_valid(core_resp_valid),
        .o_core_ready(core_resp_ready),
        .i_r0_data   (r0_resp_data),    .i_r0_valid  (r0_resp_valid),
        .o_r0_ready  (r0_resp_ready),
        .o_resp_data (o_resp_data),     .o_resp_valid(o_resp_valid),
        .i_resp_ready(i_resp_ready)
    );

endmodule

// ==== bench/b200_ctrl_core_tb.sv ====
// testbench for the control path: table-driven settings and readback,
// PPS select, radio echo and a back-pressure burst with any-order responses

module b200_ctrl_core_tb;

    localparam int          N_ROWS      = 11;
    localparam int          WAIT_MAX    = 50;                      // cycles per handshake
    localparam logic [63:0] COMPAT_WORD = 64'hACE0_BA5E_0008_0000; // magic, major, minor
    localparam logic [63:0] LOCK_WORD   = 64'h2;                   // lock bits 2'b10

    logic        radio_clk;
    logic        bus_rst;
    logic [63:0] i_ctrl_data;
    logic        i_ctrl_valid;
    logic        o_ctrl_ready;
    logic [63:0] o_resp_data;
    logic        o_resp_valid;
    logic        i_resp_ready;
    logic [1:0]  i_lock_signals;
    logic [31:0] i_rb_misc;
    logic        i_pps_int;
    logic        i_pps_ext;
    logic [31:0] o_misc_outs;
    logic        o_pps;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and expected table
    ////////////////////////////////////////////////////////////////////////////
    string       t_name    [N_ROWS];
    logic [63:0] t_cmd     [N_ROWS];
    logic        t_pps_int [N_ROWS];
    logic        t_pps_ext [N_ROWS];
    logic [1:0]  t_lock    [N_ROWS];
    logic [63:0] t_exp     [N_ROWS];
    int          t_side    [N_ROWS];  // -1 none, 0 or 1 expected o_pps, 2 misc outs

    int          n_val_err;
    int          n_to_err;
    logic [31:0] misc_val;
    logic [31:0] echo_val;
    logic        ready_fell;       // o_ctrl_ready seen low
    logic [63:0] pending [$];      // burst responses not yet seen

    b200_ctrl_core uut (.*);

    initial begin
        radio_clk = 1'b0;
        forever #4 radio_clk = ~radio_clk;
    end

    // hard stop if a handshake never completes
    initial begin
        repeat ((N_ROWS + 20) * 50) @(posedge radio_clk);
        $display("watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [63:0] make_cmd(input logic [7:0] sid, input logic [7:0] addr,
                                             input logic [31:0] data);
        return {data, 16'h0000, addr, sid};
    endfunction

    task automatic set_row(input int idx, input string name, input logic [63:0] cmd,
                           input logic pint, input logic pext, input logic [1:0] lock,
                           input logic [63:0] exp, input int side);
        t_name[idx]    = name;
        t_cmd[idx]     = cmd;
        t_pps_int[idx] = pint;
        t_pps_ext[idx] = pext;
        t_lock[idx]    = lock;
        t_exp[idx]     = exp;
        t_side[idx]    = side;
    endtask

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            n_val_err++;
        end
    endtask

    // call at posedge + 1, returns at posedge + 1 after the transfer
    task automatic send_cmd(input logic [63:0] word);
        logic rdy;
        int   n;
        rdy          = 1'b0;
        n            = 0;
        i_ctrl_data  = word;
        i_ctrl_valid = 1'b1;
        while (!rdy && n < WAIT_MAX) begin
            @(negedge radio_clk);
            rdy = o_ctrl_ready;
            if (!rdy) ready_fell = 1'b1;
            @(posedge radio_clk);
            #1;
            n++;
        end
        i_ctrl_valid = 1'b0;
        if (!rdy) begin
            $display("command %h was never accepted", word);
            n_to_err++;
        end
    endtask

    task automatic take_resp(output logic [63:0] data);
        int n;
        n    = 0;
        data = 'x;
        @(negedge radio_clk);
        while (!o_resp_valid && n < WAIT_MAX) begin
            @(negedge radio_clk);
            n++;
        end
        if (o_resp_valid) begin
            data = o_resp_data;            // taken at the next edge
        end else begin
            $display("no response arrived within %0d cycles", WAIT_MAX);
            n_to_err++;
        end
        @(posedge radio_clk);
        #1;
    endtask

    initial begin
        logic [63:0] got;
        logic [63:0] word;
        int          found;
        int          extra;

        void'($urandom(27));
        misc_val       = $urandom;
        echo_val       = $urandom & 32'hffff_fffc; // low bits clear so a stray select write shows
        i_rb_misc      = $urandom;
        bus_rst        = 1'b1;
        i_ctrl_data    = '0;
        i_ctrl_valid   = 1'b0;
        i_resp_ready   = 1'b1;
        i_lock_signals = 2'b00;
        i_pps_int      = 1'b0;
        i_pps_ext      = 1'b0;
        n_val_err      = 0;
        n_to_err       = 0;
        ready_fell     = 1'b0;

        set_row(0, "compat_after_reset", make_cmd(8'h40, 8'd0, 32'h0), 0, 0, 2'b01,
                COMPAT_WORD, -1);
        set_row(1, "misc_write_other_sid", make_cmd(8'h05, 8'd16, misc_val), 0, 0, 2'b01,
                COMPAT_WORD, -1);
        set_row(2, "rb_sel_misc", make_cmd(8'h40, 8'd32, 32'd1), 0, 0, 2'b01,
                {32'h0, misc_val}, 2);
        set_row(3, "gpsdo_status_write", make_cmd(8'h4f, 8'd40, 32'h5a), 0, 0, 2'b01,
                {32'h0, misc_val}, -1);
        set_row(4, "rb_sel_status", make_cmd(8'h40, 8'd32, 32'd2), 0, 0, 2'b01,
                {16'h0, 8'h01, 8'h5a, i_rb_misc}, -1);
        set_row(5, "rb_sel_lock", make_cmd(8'h40, 8'd32, 32'd3), 0, 0, 2'b10, LOCK_WORD, -1);
        set_row(6, "pps_sel_gpsdo", make_cmd(8'h40, 8'd48, 32'd0), 1, 0, 2'b10, LOCK_WORD, 1);
        set_row(7, "pps_sel_ext", make_cmd(8'h40, 8'd48, 32'd1), 0, 1, 2'b10, LOCK_WORD, 1);
        set_row(8, "pps_sel_low", make_cmd(8'h40, 8'd48, 32'd2), 1, 1, 2'b10, LOCK_WORD, 0);
        set_row(9, "radio_echo", make_cmd(8'h1c, 8'd32, echo_val), 1, 1, 2'b10,
                make_cmd(8'h1c, 8'd32, echo_val), -1);
        // radio write to address 32 must leave the core readback select alone
        set_row(10, "core_after_radio", make_cmd(8'h40, 8'd0, 32'h0), 1, 1, 2'b10,
                LOCK_WORD, -1);

        repeat (8) @(posedge radio_clk);
        #1;
        bus_rst = 1'b0;

        ////////////////////////////////////////////////////////////////////////////
        // table rows, one command and one response each
        ////////////////////////////////////////////////////////////////////////////
        for (int i = 0; i < N_ROWS; i++) begin
            i_pps_int      = t_pps_int[i];
            i_pps_ext      = t_pps_ext[i];
            i_lock_signals = t_lock[i];
            repeat (4) @(posedge radio_clk);  // let the synchronizers settle
            #1;
            send_cmd(t_cmd[i]);
            take_resp(got);
            check_val(t_name[i], t_exp[i], got);
            if (t_side[i] >= 0) begin
                repeat (4) @(negedge radio_clk);
                if (t_side[i] == 2)
                    check_val({t_name[i], " misc_outs"}, {32'h0, misc_val}, {32'h0, o_misc_outs});
                else
                    check_val({t_name[i], " pps"}, 64'(t_side[i]), {63'h0, o_pps});
                @(posedge radio_clk);
                #1;
            end
        end

        ////////////////////////////////////////////////////////////////////////////
        // back-pressure burst
        ////////////////////////////////////////////////////////////////////////////
        // four beats fill arbiter, core, echo and demux so ready has to drop
        ready_fell   = 1'b0;
        i_resp_ready = 1'b0;
        word = make_cmd(8'h12, 8'h55, $urandom);
        pending.push_back(word);
        send_cmd(word);
        send_cmd(make_cmd(8'h40, 8'd0, 32'h0));
        pending.push_back(LOCK_WORD);
        word = make_cmd(8'h17, 8'h09, $urandom);
        pending.push_back(word);
        send_cmd(word);
        send_cmd(make_cmd(8'h40, 8'd16, $urandom));   // misc write, still lock readback
        pending.push_back(LOCK_WORD);
        repeat (3) begin
            @(negedge radio_clk);
            if (!o_ctrl_ready) ready_fell = 1'b1;
        end
        assert (ready_fell) else begin
            $display("o_ctrl_ready never fell while responses were held");
            n_val_err++;
        end

        @(posedge radio_clk);
        #1;
        i_resp_ready = 1'b1;
        for (int k = 0; k < 4; k++) begin
            take_resp(got);
            found = -1;
            foreach (pending[j]) begin
                if (found < 0 && pending[j] === got) found = j;
            end
            assert (found >= 0) else begin
                $display("FAILED burst_resp: expected %h or another pending word, actual %h",
                         pending[0], got);
                n_val_err++;
            end
            if (found >= 0) pending.delete(found);
        end

        extra = 0;
        repeat (10) begin
            @(negedge radio_clk);
            if (o_resp_valid) extra++;
        end
        check_val("burst_extra_beats", 64'd0, 64'(extra));

        $display("errors: %0d value, %0d timeout", n_val_err, n_to_err);
        if (n_val_err == 0 && n_to_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== b200_ctrl_core.f ====
rtl/b200_ctrl_pkg.sv
rtl/ctrl_demux.sv
rtl/core_ctrl.sv
rtl/radio_ctrl_echo.sv
rtl/resp_arbiter.sv
rtl/b200_ctrl_core.sv
bench/b200_ctrl_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the control path testbench with Verilator
set -euo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module b200_ctrl_core_tb \
    -f b200_ctrl_core.f \
    -o sim_b200_ctrl_core

./obj_dir/sim_b200_ctrl_core | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation finished, log in sim.log"
